/* src/tdu_pkg.sv */
// Trigger unit shared definitions
package tdu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int TDU_DATA_W  = 32;
	localparam int MTRIG_NUM   = 4;              // match-control triggers
	localparam int ALLTRIG_NUM = MTRIG_NUM + 1;  // plus icount
	localparam int TSEL_W      = 3;
	localparam int ICOUNT_W    = 14;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tdata1 field positions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int TDATA1_TYPE_HI = 31;
	localparam int TDATA1_TYPE_LO = 28;
	localparam int TDATA1_DMODE   = 27;

	// mcontrol layout
	localparam int MCTL_HIT       = 20;
	localparam int MCTL_ACTION_HI = 17;
	localparam int MCTL_ACTION_LO = 12;
	localparam int MCTL_M         = 6;
	localparam int MCTL_EXECUTE   = 2;
	localparam int MCTL_STORE     = 1;
	localparam int MCTL_LOAD      = 0;

	// icount layout
	localparam int ICNT_HIT       = 24;
	localparam int ICNT_COUNT_HI  = 23;
	localparam int ICNT_COUNT_LO  = 10;
	localparam int ICNT_M         = 9;
	localparam int ICNT_ACTION_HI = 5;
	localparam int ICNT_ACTION_LO = 0;

	// type and action codes
	localparam logic [3:0] TYPE_MCONTROL = 4'd2;
	localparam logic [3:0] TYPE_ICOUNT   = 4'd3;
	localparam logic [5:0] ACTION_DMODE  = 6'd1;  // enter debug mode

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CSR command and window address
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		CSR_CMD_READ  = 2'd0,
		CSR_CMD_WRITE = 2'd1,
		CSR_CMD_SET   = 2'd2,
		CSR_CMD_CLEAR = 2'd3
	} csr_cmd_e;

	typedef enum logic [2:0] {
		ADDR_TSELECT = 3'd0,
		ADDR_TDATA1  = 3'd1,
		ADDR_TDATA2  = 3'd2,
		ADDR_TINFO   = 3'd4
	} tdu_addr_e;

endpackage

/* src/tdu_csr_access.sv */
// Trigger CSR window access
`timescale 1ns/10ps

module tdu_csr_access import tdu_pkg::*; (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  csr_req_i,
	input  csr_cmd_e                              csr_cmd_i,
	input  tdu_addr_e                             csr_addr_i,
	input  logic [TDU_DATA_W-1:0]                 csr_wdata_i,
	input  logic [MTRIG_NUM-1:0][TDU_DATA_W-1:0]  mctl_tdata1_i,
	input  logic [MTRIG_NUM-1:0][TDU_DATA_W-1:0]  mctl_tdata2_i,
	input  logic [TDU_DATA_W-1:0]                 icnt_tdata1_i,
	output logic [TDU_DATA_W-1:0]                 csr_rdata_o,
	output logic [TDU_DATA_W-1:0]                 wr_data_o,
	output logic [MTRIG_NUM-1:0]                  mctl_tdata1_wr_o,
	output logic [MTRIG_NUM-1:0]                  mctl_tdata2_wr_o,
	output logic                                  icnt_tdata1_wr_o
);

	logic [TSEL_W-1:0] tsel;
	logic              wr_req;
	logic              sel_icnt;  // icount is the last trigger

	assign sel_icnt = (tsel == TSEL_W'(ALLTRIG_NUM - 1));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read mux
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		csr_rdata_o = '0;
		if (csr_req_i) begin
			case (csr_addr_i)
				ADDR_TSELECT: csr_rdata_o = TDU_DATA_W'(tsel);
				ADDR_TDATA1: begin
					for (int i = 0; i < MTRIG_NUM; i++)
						if (tsel == TSEL_W'(i))
							csr_rdata_o = mctl_tdata1_i[i];
					if (sel_icnt)
						csr_rdata_o = icnt_tdata1_i;
				end
				ADDR_TDATA2: begin
					for (int i = 0; i < MTRIG_NUM; i++)
						if (tsel == TSEL_W'(i))
							csr_rdata_o = mctl_tdata2_i[i];  // icount has none
				end
				ADDR_TINFO: begin
					if (sel_icnt)
						csr_rdata_o[TYPE_ICOUNT] = 1'b1;
					else
						csr_rdata_o[TYPE_MCONTROL] = 1'b1;
				end
				default: csr_rdata_o = '0;
			endcase
		end
	end

	// write data per command
	// zero mask set or clear is no write
	always_comb begin
		wr_req    = 1'b0;
		wr_data_o = '0;
		case (csr_cmd_i)
			CSR_CMD_READ: wr_req = 1'b0;
			CSR_CMD_WRITE: begin
				wr_req    = 1'b1;
				wr_data_o = csr_wdata_i;
			end
			CSR_CMD_SET: begin
				wr_req    = |csr_wdata_i;
				wr_data_o = csr_rdata_o | csr_wdata_i;
			end
			CSR_CMD_CLEAR: begin
				wr_req    = |csr_wdata_i;
				wr_data_o = csr_rdata_o & ~csr_wdata_i;
			end
			default: wr_req = 1'b0;
		endcase
	end

	// write strobes
	always_comb begin
		mctl_tdata1_wr_o = '0;
		mctl_tdata2_wr_o = '0;
		icnt_tdata1_wr_o = csr_req_i & wr_req & (csr_addr_i == ADDR_TDATA1) & sel_icnt;
		for (int i = 0; i < MTRIG_NUM; i++) begin
			if (csr_req_i && wr_req && tsel == TSEL_W'(i)) begin
				mctl_tdata1_wr_o[i] = (csr_addr_i == ADDR_TDATA1);
				mctl_tdata2_wr_o[i] = (csr_addr_i == ADDR_TDATA2);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			tsel <= '0;
		else if (csr_req_i && wr_req && csr_addr_i == ADDR_TSELECT &&
				wr_data_o < TDU_DATA_W'(ALLTRIG_NUM))
			tsel <= wr_data_o[TSEL_W-1:0];  // out of range values dropped
	end

	a_tsel_range: assert property (@(posedge clk) disable iff (!rst_n)
		tsel < TSEL_W'(ALLTRIG_NUM));

	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({mctl_tdata1_wr_o, mctl_tdata2_wr_o, icnt_tdata1_wr_o}));

endmodule

/* src/tdu_mcontrol_trig.sv */
// Match-control trigger
`timescale 1ns/10ps

module tdu_mcontrol_trig import tdu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tdu_dsbl_i,
	input  logic                  tdata1_wr_i,
	input  logic                  tdata2_wr_i,
	input  logic [TDU_DATA_W-1:0] wr_data_i,
	input  logic                  imon_vd_i,
	input  logic [TDU_DATA_W-1:0] imon_addr_i,
	input  logic                  dmon_vd_i,
	input  logic                  dmon_load_i,
	input  logic                  dmon_store_i,
	input  logic [TDU_DATA_W-1:0] dmon_addr_i,
	input  logic                  bp_retire_i,
	output logic [TDU_DATA_W-1:0] tdata1_o,
	output logic [TDU_DATA_W-1:0] tdata2_o,
	output logic                  exec_hit_o,
	output logic                  ldst_hit_o,
	output logic                  dmode_req_o
);

	logic dmode;
	logic m;
	logic execute;
	logic load;
	logic store;
	logic action;  // action == enter debug mode
	logic hit;
	logic [TDU_DATA_W-1:0] tdata2;

	logic wr_ok;  // dmode trigger locked outside debug mode
	logic tdata1_upd;
	logic tdata2_upd;
	logic active;

	assign wr_ok      = ~dmode | tdu_dsbl_i;
	assign tdata1_upd = tdata1_wr_i & wr_ok;
	assign tdata2_upd = tdata2_wr_i & wr_ok;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dmode   <= 1'b0;
			m       <= 1'b0;
			execute <= 1'b0;
			load    <= 1'b0;
			store   <= 1'b0;
			action  <= 1'b0;
			hit     <= 1'b0;
		end else if (tdata1_upd) begin
			dmode   <= wr_data_i[TDATA1_DMODE];
			m       <= wr_data_i[MCTL_M];
			execute <= wr_data_i[MCTL_EXECUTE];
			load    <= wr_data_i[MCTL_LOAD];
			store   <= wr_data_i[MCTL_STORE];
			action  <= (wr_data_i[MCTL_ACTION_HI:MCTL_ACTION_LO] == ACTION_DMODE);
			hit     <= wr_data_i[MCTL_HIT];
		end else if (bp_retire_i) begin
			hit <= 1'b1;  // sticky until software clears it
		end
	end

	always_ff @(posedge clk) begin
		if (tdata2_upd)
			tdata2 <= wr_data_i;
	end

	// readback image
	always_comb begin
		tdata1_o = '0;
		tdata1_o[TDATA1_TYPE_HI:TDATA1_TYPE_LO] = TYPE_MCONTROL;
		tdata1_o[TDATA1_DMODE]                  = dmode;
		tdata1_o[MCTL_HIT]                      = hit;
		tdata1_o[MCTL_ACTION_HI:MCTL_ACTION_LO] = action ? ACTION_DMODE : '0;
		tdata1_o[MCTL_M]                        = m;
		tdata1_o[MCTL_EXECUTE]                  = execute;
		tdata1_o[MCTL_STORE]                    = store;
		tdata1_o[MCTL_LOAD]                     = load;
	end

	assign tdata2_o = tdata2;

	// matching
	assign active     = ~tdu_dsbl_i & m;
	assign exec_hit_o = active & execute & imon_vd_i & (imon_addr_i == tdata2);
	assign ldst_hit_o = active & dmon_vd_i &
		((load & dmon_load_i) | (store & dmon_store_i)) & (dmon_addr_i == tdata2);

	assign dmode_req_o = action & bp_retire_i;

	a_no_hit_wo_m: assert property (@(posedge clk) disable iff (!rst_n)
		!m |-> !(exec_hit_o || ldst_hit_o));

endmodule

/* src/tdu_icount_trig.sv */
// Instruction count trigger
`timescale 1ns/10ps

module tdu_icount_trig import tdu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tdu_dsbl_i,
	input  logic                  tdata1_wr_i,
	input  logic [TDU_DATA_W-1:0] wr_data_i,
	input  logic                  imon_vd_i,
	input  logic                  imon_req_i,
	input  logic                  bp_retire_i,
	output logic [TDU_DATA_W-1:0] tdata1_o,
	output logic                  hit_o,
	output logic                  dmode_req_o
);

	logic                dmode;
	logic                m;
	logic                action;
	logic                hit;
	logic [ICOUNT_W-1:0] count;
	logic                skip;  // first retirement after arming

	logic upd;
	logic qual;
	logic decr;
	logic skip_clr;

	assign upd = tdata1_wr_i & (~dmode | tdu_dsbl_i);

	// qualified retirement
	assign qual     = ~tdu_dsbl_i & m & imon_vd_i & imon_req_i & (count != '0);
	assign decr     = qual & ~skip;
	assign skip_clr = qual & skip;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fields and counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dmode  <= 1'b0;
			m      <= 1'b0;
			action <= 1'b0;
			hit    <= 1'b0;
			count  <= '0;
		end else if (upd) begin
			dmode  <= wr_data_i[TDATA1_DMODE];
			m      <= wr_data_i[ICNT_M];
			action <= (wr_data_i[ICNT_ACTION_HI:ICNT_ACTION_LO] == ACTION_DMODE);
			hit    <= wr_data_i[ICNT_HIT];
			count  <= wr_data_i[ICNT_COUNT_HI:ICNT_COUNT_LO];
		end else begin
			if (bp_retire_i)
				hit <= 1'b1;
			if (decr)
				count <= count - 1'b1;
		end
	end

	// skip tracks every write including blocked ones
	always_ff @(posedge clk) begin
		if (!rst_n)
			skip <= 1'b0;
		else if (tdata1_wr_i)
			skip <= wr_data_i[ICNT_M];
		else if (skip_clr)
			skip <= 1'b0;
	end

	always_comb begin
		tdata1_o = '0;
		tdata1_o[TDATA1_TYPE_HI:TDATA1_TYPE_LO] = TYPE_ICOUNT;
		tdata1_o[TDATA1_DMODE]                  = dmode;
		tdata1_o[ICNT_HIT]                      = hit;
		tdata1_o[ICNT_COUNT_HI:ICNT_COUNT_LO]   = count;
		tdata1_o[ICNT_M]                        = m;
		tdata1_o[ICNT_ACTION_HI:ICNT_ACTION_LO] = action ? ACTION_DMODE : '0;
	end

	// fires on the last counted instruction
	assign hit_o = ~tdu_dsbl_i & m & imon_vd_i & (count == ICOUNT_W'(1)) & ~skip;

	assign dmode_req_o = action & bp_retire_i;

	// an empty counter stays empty unless rewritten
	a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		(count == '0 && !upd) |=> count == '0);

endmodule

/* src/tdu_top.sv */
// Debug trigger unit top
`timescale 1ns/10ps

module tdu_top import tdu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   tdu_dsbl_i,
	// CSR window
	input  logic                   csr_req_i,
	input  csr_cmd_e               csr_cmd_i,
	input  tdu_addr_e              csr_addr_i,
	input  logic [TDU_DATA_W-1:0]  csr_wdata_i,
	output logic [TDU_DATA_W-1:0]  csr_rdata_o,
	// instruction monitor
	input  logic                   imon_vd_i,
	input  logic                   imon_req_i,
	input  logic [TDU_DATA_W-1:0]  imon_addr_i,
	// data monitor
	input  logic                   dmon_vd_i,
	input  logic                   dmon_load_i,
	input  logic                   dmon_store_i,
	input  logic [TDU_DATA_W-1:0]  dmon_addr_i,
	input  logic [ALLTRIG_NUM-1:0] bp_retire_i,
	output logic [ALLTRIG_NUM-1:0] ibrkpt_match_o,
	output logic                   ibrkpt_exc_req_o,
	output logic [MTRIG_NUM-1:0]   dbrkpt_match_o,
	output logic                   dbrkpt_exc_req_o,
	output logic                   dmode_req_o
);

	logic [TDU_DATA_W-1:0]                wr_data;
	logic [MTRIG_NUM-1:0]                 mctl_tdata1_wr;
	logic [MTRIG_NUM-1:0]                 mctl_tdata2_wr;
	logic                                 icnt_tdata1_wr;
	logic [MTRIG_NUM-1:0][TDU_DATA_W-1:0] mctl_tdata1;
	logic [MTRIG_NUM-1:0][TDU_DATA_W-1:0] mctl_tdata2;
	logic [TDU_DATA_W-1:0]                icnt_tdata1;
	logic [MTRIG_NUM-1:0]                 exec_hit;
	logic [MTRIG_NUM-1:0]                 ldst_hit;
	logic [MTRIG_NUM-1:0]                 mctl_dmode_req;
	logic                                 icnt_hit;
	logic                                 icnt_dmode_req;

	tdu_csr_access u_csr (
		.clk              (clk),
		.rst_n            (rst_n),
		.csr_req_i        (csr_req_i),
		.csr_cmd_i        (csr_cmd_i),
		.csr_addr_i       (csr_addr_i),
		.csr_wdata_i      (csr_wdata_i),
		.mctl_tdata1_i    (mctl_tdata1),
		.mctl_tdata2_i    (mctl_tdata2),
		.icnt_tdata1_i    (icnt_tdata1),
		.csr_rdata_o      (csr_rdata_o),
		.wr_data_o        (wr_data),
		.mctl_tdata1_wr_o (mctl_tdata1_wr),
		.mctl_tdata2_wr_o (mctl_tdata2_wr),
		.icnt_tdata1_wr_o (icnt_tdata1_wr)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// match-control triggers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar t = 0; t < MTRIG_NUM; t++) begin : g_mtrig
		tdu_mcontrol_trig u_mtrig (
			.clk          (clk),
			.rst_n        (rst_n),
			.tdu_dsbl_i   (tdu_dsbl_i),
			.tdata1_wr_i  (mctl_tdata1_wr[t]),
			.tdata2_wr_i  (mctl_tdata2_wr[t]),
			.wr_data_i    (wr_data),
			.imon_vd_i    (imon_vd_i),
			.imon_addr_i  (imon_addr_i),
			.dmon_vd_i    (dmon_vd_i),
			.dmon_load_i  (dmon_load_i),
			.dmon_store_i (dmon_store_i),
			.dmon_addr_i  (dmon_addr_i),
			.bp_retire_i  (bp_retire_i[t]),
			.tdata1_o     (mctl_tdata1[t]),
			.tdata2_o     (mctl_tdata2[t]),
			.exec_hit_o   (exec_hit[t]),
			.ldst_hit_o   (ldst_hit[t]),
			.dmode_req_o  (mctl_dmode_req[t])
		);
	end

	tdu_icount_trig u_icnt (
		.clk         (clk),
		.rst_n       (rst_n),
		.tdu_dsbl_i  (tdu_dsbl_i),
		.tdata1_wr_i (icnt_tdata1_wr),
		.wr_data_i   (wr_data),
		.imon_vd_i   (imon_vd_i),
		.imon_req_i  (imon_req_i),
		.bp_retire_i (bp_retire_i[ALLTRIG_NUM-1]),
		.tdata1_o    (icnt_tdata1),
		.hit_o       (icnt_hit),
		.dmode_req_o (icnt_dmode_req)
	);

	assign ibrkpt_match_o   = {icnt_hit, exec_hit};  // icount on top
	assign ibrkpt_exc_req_o = |exec_hit | icnt_hit;
	assign dbrkpt_match_o   = ldst_hit;
	assign dbrkpt_exc_req_o = |ldst_hit;
	assign dmode_req_o      = |mctl_dmode_req | icnt_dmode_req;

endmodule

/* tests/tdu_tb_cases.svh */
// Trigger unit test table

// row columns are name, command, address, write data, monitor flags,
// monitor address, retire bits, expected rdata and expected outputs

localparam csr_cmd_e  C_RD  = CSR_CMD_READ;
localparam csr_cmd_e  C_WR  = CSR_CMD_WRITE;
localparam csr_cmd_e  C_ST  = CSR_CMD_SET;
localparam csr_cmd_e  C_CL  = CSR_CMD_CLEAR;
localparam tdu_addr_e A_SEL = ADDR_TSELECT;
localparam tdu_addr_e A_D1  = ADDR_TDATA1;
localparam tdu_addr_e A_D2  = ADDR_TDATA2;
localparam tdu_addr_e A_INF = ADDR_TINFO;

localparam logic [5:0] M_NONE = 6'b000000;
localparam logic [5:0] M_DSBL = 6'b100000;
localparam logic [5:0] M_IVD  = 6'b010000;
localparam logic [5:0] M_IREQ = 6'b001000;
localparam logic [5:0] M_DVD  = 6'b000100;
localparam logic [5:0] M_LD   = 6'b000010;
localparam logic [5:0] M_ST   = 6'b000001;

// {ibrkpt_match, ibrkpt_exc, dbrkpt_match, dbrkpt_exc, dmode_req}
localparam logic [11:0] O_NONE  = 12'b00000_0_0000_0_0;
localparam logic [11:0] O_EXEC1 = 12'b00010_1_0000_0_0;
localparam logic [11:0] O_LD2   = 12'b00000_0_0100_1_0;
localparam logic [11:0] O_ICNT  = 12'b10000_1_0000_0_0;
localparam logic [11:0] O_DMODE = 12'b00000_0_0000_0_1;

task automatic add_row(input string name, input csr_cmd_e cmd, input tdu_addr_e addr,
		input logic [31:0] wdata, input logic [5:0] mon, input logic [31:0] maddr,
		input logic [4:0] ret, input logic [31:0] exp_rd, input logic [11:0] exp_out);
	name_q.push_back(name);
	cmd_q.push_back(cmd);
	addr_q.push_back(addr);
	wdata_q.push_back(wdata);
	mon_q.push_back(mon);
	maddr_q.push_back(maddr);
	ret_q.push_back(ret);
	exp_rd_q.push_back(exp_rd);
	exp_out_q.push_back(exp_out);
endtask

// rdata shows the state before the row's own write lands
task automatic load_cases();
	add_row("tsel_wr1", C_WR, A_SEL, 32'd1, M_NONE, 32'h0, 5'h0, 32'd0, O_NONE);
	add_row("tsel_wr4", C_WR, A_SEL, 32'd4, M_NONE, 32'h0, 5'h0, 32'd1, O_NONE);
	add_row("tsel_wr5", C_WR, A_SEL, 32'd5, M_NONE, 32'h0, 5'h0, 32'd4, O_NONE);
	add_row("tsel_wr7", C_WR, A_SEL, 32'd7, M_NONE, 32'h0, 5'h0, 32'd4, O_NONE);
	add_row("tinfo_t4", C_RD, A_INF, 32'd0, M_NONE, 32'h0, 5'h0, 32'd8, O_NONE);
	add_row("tsel_wr2", C_WR, A_SEL, 32'd2, M_NONE, 32'h0, 5'h0, 32'd4, O_NONE);
	add_row("tinfo_t2", C_RD, A_INF, 32'd0, M_NONE, 32'h0, 5'h0, 32'd4, O_NONE);
	add_row("tsel_wr3", C_WR, A_SEL, 32'd3, M_NONE, 32'h0, 5'h0, 32'd2, O_NONE);
	add_row("tsel_wr0", C_WR, A_SEL, 32'd0, M_NONE, 32'h0, 5'h0, 32'd3, O_NONE);
	// tdata1 field access on trigger 0
	add_row("t1_wr_all", C_WR, A_D1, 32'hf7ff_ffff, M_NONE, 32'h0, 5'h0, 32'h2000_0000, O_NONE);
	add_row("t1_clr", C_CL, A_D1, 32'h0010_0005, M_NONE, 32'h0, 5'h0, 32'h2010_0047, O_NONE);
	add_row("t1_set", C_ST, A_D1, 32'h0000_1004, M_NONE, 32'h0, 5'h0, 32'h2000_0042, O_NONE);
	// zero mask rows retire trigger 0 so a stray write would drop hit
	add_row("t1_set0", C_ST, A_D1, 32'h0, M_NONE, 32'h0, 5'h1, 32'h2000_1046, O_DMODE);
	add_row("t1_hit_clr", C_CL, A_D1, 32'h0010_0000, M_NONE, 32'h0, 5'h0, 32'h2010_1046, O_NONE);
	add_row("t1_clr0", C_CL, A_D1, 32'h0, M_NONE, 32'h0, 5'h1, 32'h2000_1046, O_DMODE);
	add_row("t1_wr0", C_WR, A_D1, 32'h0, M_NONE, 32'h0, 5'h0, 32'h2010_1046, O_NONE);
	// execute breakpoint on trigger 1
	add_row("exec_sel", C_WR, A_SEL, 32'd1, M_NONE, 32'h0, 5'h0, 32'd0, O_NONE);
	add_row("exec_t2", C_WR, A_D2, rnd_a, M_NONE, 32'h0, 5'h0, SKIP_RD, O_NONE);
	add_row("exec_t1", C_WR, A_D1, 32'h44, M_NONE, 32'h0, 5'h0, 32'h2000_0000, O_NONE);
	add_row("exec_hit", C_RD, A_D2, 32'h0, M_IVD, rnd_a, 5'h0, rnd_a, O_EXEC1);
	add_row("exec_miss", C_RD, A_D1, 32'h0, M_IVD, miss_addr, 5'h0, 32'h2000_0044, O_NONE);
	add_row("exec_dsbl", C_RD, A_INF, 32'h0, M_DSBL | M_IVD, rnd_a, 5'h0, 32'd4, O_NONE);
	// load and store watchpoint on trigger 2
	add_row("ld_sel", C_WR, A_SEL, 32'd2, M_NONE, 32'h0, 5'h0, 32'd1, O_NONE);
	add_row("ld_t2", C_WR, A_D2, rnd_b, M_NONE, 32'h0, 5'h0, SKIP_RD, O_NONE);
	add_row("ld_t1", C_WR, A_D1, 32'h41, M_NONE, 32'h0, 5'h0, 32'h2000_0000, O_NONE);
	add_row("ld_hit", C_RD, A_D2, 32'h0, M_DVD | M_LD, rnd_b, 5'h0, rnd_b, O_LD2);
	add_row("ld_st_miss", C_WR, A_D1, 32'h42, M_DVD | M_ST, rnd_b, 5'h0, 32'h2000_0041, O_NONE);
	add_row("st_hit", C_RD, A_D1, 32'h0, M_DVD | M_ST, rnd_b, 5'h0, 32'h2000_0042, O_LD2);
	add_row("st_ld_miss", C_WR, A_SEL, 32'd4, M_DVD | M_LD, rnd_b, 5'h0, 32'd2, O_NONE);
	// instruction count of 3 with the first retirement skipped
	add_row("icnt_wr", C_WR, A_D1, 32'h0e00, M_NONE, 32'h0, 5'h0, 32'h3000_0000, O_NONE);
	add_row("icnt_skip", C_RD, A_D1, 32'h0, M_IVD | M_IREQ, miss_addr, 5'h0, 32'h3000_0e00, O_NONE);
	add_row("icnt_dec3", C_RD, A_D1, 32'h0, M_IVD | M_IREQ, miss_addr, 5'h0, 32'h3000_0e00, O_NONE);
	add_row("icnt_dec2", C_RD, A_D1, 32'h0, M_IVD | M_IREQ, miss_addr, 5'h0, 32'h3000_0a00, O_NONE);
	add_row("icnt_fire", C_RD, A_D1, 32'h0, M_IVD, miss_addr, 5'h0, 32'h3000_0600, O_ICNT);
	add_row("icnt_last", C_RD, A_D1, 32'h0, M_IVD | M_IREQ, miss_addr, 5'h0, 32'h3000_0600, O_ICNT);
	add_row("icnt_empty", C_RD, A_D1, 32'h0, M_IVD | M_IREQ, miss_addr, 5'h0, 32'h3000_0200, O_NONE);
	// debug mode action and dmode lock on trigger 3
	add_row("dm_sel", C_WR, A_SEL, 32'd3, M_NONE, 32'h0, 5'h0, 32'd4, O_NONE);
	add_row("dm_wr", C_WR, A_D1, 32'h1040, M_NONE, 32'h0, 5'h0, 32'h2000_0000, O_NONE);
	add_row("dm_retire", C_RD, A_D1, 32'h0, M_NONE, 32'h0, 5'h8, 32'h2000_1040, O_DMODE);
	add_row("dm_lock", C_WR, A_D1, 32'h0800_1040, M_NONE, 32'h0, 5'h0, 32'h2010_1040, O_NONE);
	add_row("dm_blocked", C_WR, A_D1, 32'h0, M_NONE, 32'h0, 5'h0, 32'h2800_1040, O_NONE);
	add_row("dm_unlock", C_WR, A_D1, 32'h40, M_DSBL, 32'h0, 5'h0, 32'h2800_1040, O_NONE);
	add_row("dm_check", C_RD, A_D1, 32'h0, M_NONE, 32'h0, 5'h0, 32'h2000_0040, O_NONE);
endtask

/* tests/tdu_tb.sv */
// Trigger unit testbench
`timescale 1ns/10ps

module tdu_tb
	import tdu_pkg::*;
();

	localparam logic [31:0] SEED         = 32'h2bf9_ce11;
	localparam logic [31:0] SKIP_RD      = 32'hffff_ffff;  // rdata not compared
	localparam int          IDLE_TIMEOUT = 16;

	logic                   clk;
	logic                   rst_n;
	logic                   tdu_dsbl;
	logic                   csr_req;
	csr_cmd_e               csr_cmd;
	tdu_addr_e              csr_addr;
	logic [TDU_DATA_W-1:0]  csr_wdata;
	logic [TDU_DATA_W-1:0]  csr_rdata;
	logic                   imon_vd;
	logic                   imon_req;
	logic [TDU_DATA_W-1:0]  imon_addr;
	logic                   dmon_vd;
	logic                   dmon_load;
	logic                   dmon_store;
	logic [TDU_DATA_W-1:0]  dmon_addr;
	logic [ALLTRIG_NUM-1:0] bp_retire;
	logic [ALLTRIG_NUM-1:0] ibrkpt_match;
	logic                   ibrkpt_exc_req;
	logic [MTRIG_NUM-1:0]   dbrkpt_match;
	logic                   dbrkpt_exc_req;
	logic                   dmode_req;
	logic [11:0]            out_vec;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test table storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	string       name_q[$];
	csr_cmd_e    cmd_q[$];
	tdu_addr_e   addr_q[$];
	logic [31:0] wdata_q[$];
	logic [5:0]  mon_q[$];    // {dsbl, ivd, ireq, dvd, load, store}
	logic [31:0] maddr_q[$];
	logic [4:0]  ret_q[$];
	logic [31:0] exp_rd_q[$];
	logic [11:0] exp_out_q[$];

	int          err_cnt;
	int          chk_cnt;
	logic        idle_seen;
	logic [31:0] rnd_a;
	logic [31:0] rnd_b;
	logic [31:0] miss_addr;

	`include "tdu_tb_cases.svh"

	tdu_top dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.tdu_dsbl_i       (tdu_dsbl),
		.csr_req_i        (csr_req),
		.csr_cmd_i        (csr_cmd),
		.csr_addr_i       (csr_addr),
		.csr_wdata_i      (csr_wdata),
		.csr_rdata_o      (csr_rdata),
		.imon_vd_i        (imon_vd),
		.imon_req_i       (imon_req),
		.imon_addr_i      (imon_addr),
		.dmon_vd_i        (dmon_vd),
		.dmon_load_i      (dmon_load),
		.dmon_store_i     (dmon_store),
		.dmon_addr_i      (dmon_addr),
		.bp_retire_i      (bp_retire),
		.ibrkpt_match_o   (ibrkpt_match),
		.ibrkpt_exc_req_o (ibrkpt_exc_req),
		.dbrkpt_match_o   (dbrkpt_match),
		.dbrkpt_exc_req_o (dbrkpt_exc_req),
		.dmode_req_o      (dmode_req)
	);

	assign out_vec = {ibrkpt_match, ibrkpt_exc_req, dbrkpt_match, dbrkpt_exc_req, dmode_req};

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drive_row(input int i);
		csr_req    <= 1'b1;
		csr_cmd    <= cmd_q[i];
		csr_addr   <= addr_q[i];
		csr_wdata  <= wdata_q[i];
		tdu_dsbl   <= mon_q[i][5];
		imon_vd    <= mon_q[i][4];
		imon_req   <= mon_q[i][3];
		dmon_vd    <= mon_q[i][2];
		dmon_load  <= mon_q[i][1];
		dmon_store <= mon_q[i][0];
		imon_addr  <= maddr_q[i];  // one address feeds both monitors
		dmon_addr  <= maddr_q[i];
		bp_retire  <= ret_q[i];
	endtask

	task automatic check_row(input int i);
		if (exp_rd_q[i] != SKIP_RD) begin
			chk_cnt++;
			if (csr_rdata !== exp_rd_q[i]) begin
				err_cnt++;
				$display("mismatch %s rdata expected %h actual %h",
					name_q[i], exp_rd_q[i], csr_rdata);
			end
		end
		chk_cnt++;
		if (out_vec !== exp_out_q[i]) begin
			err_cnt++;
			$display("mismatch %s outputs expected %b actual %b",
				name_q[i], exp_out_q[i], out_vec);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		rst_n      = 1'b0;
		tdu_dsbl   = 1'b0;
		csr_req    = 1'b0;
		csr_cmd    = CSR_CMD_READ;
		csr_addr   = ADDR_TSELECT;
		csr_wdata  = '0;
		imon_vd    = 1'b0;
		imon_req   = 1'b0;
		imon_addr  = '0;
		dmon_vd    = 1'b0;
		dmon_load  = 1'b0;
		dmon_store = 1'b0;
		dmon_addr  = '0;
		bp_retire  = '0;
		err_cnt    = 0;
		chk_cnt    = 0;
		idle_seen  = 1'b0;
		rnd_a      = next_rand(SEED);
		rnd_b      = next_rand(rnd_a);
		miss_addr  = rnd_a ^ 32'h0000_0010;
		load_cases();

		repeat (4) @(posedge clk);
		rst_n   <= 1'b1;
		csr_req <= 1'b1;  // tselect read while idle

		for (int n = 0; n < IDLE_TIMEOUT && !idle_seen; n++) begin
			@(negedge clk);
			if (rst_n && csr_rdata == '0 && out_vec == '0)
				idle_seen = 1'b1;
		end

		if (!idle_seen) begin
			err_cnt++;
			$display("timeout while waiting for idle outputs after reset");
		end else begin
			for (int i = 0; i < name_q.size(); i++) begin
				@(posedge clk);
				drive_row(i);
				@(negedge clk);  // outputs settled
				check_row(i);
			end
		end

		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* tdu.f */
+incdir+tests
src/tdu_pkg.sv
src/tdu_csr_access.sv
src/tdu_mcontrol_trig.sv
src/tdu_icount_trig.sv
src/tdu_top.sv
tests/tdu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tdu_tb -f tdu.f -o tdu_sim > build.log 2>&1 \
	&& ./obj_dir/tdu_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
